// File: src.f
+incdir+bench
source/ppu_cfg_pkg.sv
source/ppu_num_pkg.sv
source/ppu_stage_if.sv
source/vector_affine.sv
source/max_stage.sv
source/reciprocal_stage.sv
source/quantize_stage.sv
source/ppu_top.sv
bench/ppu_tb.sv

// File: Bender.yml
package:
  name: ppu

sources:
  - files:
      - source/ppu_cfg_pkg.sv
      - source/ppu_num_pkg.sv
      - source/ppu_stage_if.sv
      - source/vector_affine.sv
      - source/max_stage.sv
      - source/reciprocal_stage.sv
      - source/quantize_stage.sv
      - source/ppu_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/ppu_tb.sv

// File: bench/ppu_ref.svh
`ifndef PPU_REF_SVH
`define PPU_REF_SVH
`default_nettype none

// e4m3 scale to signed q8.8, wraps at 16 bits
function automatic logic signed [15:0] fp8_decode(input logic [7:0] f);
    int          e;
    logic [15:0] base;
    logic [15:0] mag;
    e    = f[6:3];
    base = 16'd256 + 16'(f[2:0]) * 16'd32;
    if (e >= 7) begin
        mag = base << (e - 7);
    end else begin
        mag = base >> (7 - e);
    end
    if (f[7]) begin
        mag = -mag;
    end
    return $signed(mag);
endfunction

// scale twice, add bias, relu, keep bits 31..16
function automatic logic signed [15:0] lane_affine(input logic [23:0] psum,
                                                   input logic [7:0] sa,
                                                   input logic [7:0] sw,
                                                   input logic [7:0] b);
    logic signed [39:0] x;
    logic signed [39:0] a;
    logic signed [39:0] w;
    logic signed [39:0] t;
    x = $signed(psum);
    a = fp8_decode(sa);
    w = fp8_decode(sw);
    t = (x * a) >>> 8;
    t = (t * w) >>> 8;
    t = t + $signed({16'd0, b, 16'd0});
    if (t < 0) begin
        return 16'sd0;
    end
    return t[31:16];
endfunction

// index of the signed maximum, first one on a tie
function automatic int vector_max_index(input logic [255:0] lanes);
    int best;
    best = 0;
    for (int i = 1; i < 16; i++) begin
        if ($signed(lanes[16*i +: 16]) > $signed(lanes[16*best +: 16])) begin
            best = i;
        end
    end
    return best;
endfunction

function automatic logic [15:0] reciprocal_of(input logic signed [15:0] mx,
                                              input logic [1:0] mode);
    int lim;
    if (mx <= 0) begin
        return 16'hffff;
    end
    lim = (mode == 2'd0) ? 127 : 7;
    return 16'((lim * 256) / int'(mx));
endfunction

// int8 fills bytes, int4 fills the low 16 nibbles
function automatic logic [127:0] quantize_pack(input logic [255:0] lanes,
                                               input logic [15:0] recip,
                                               input logic [1:0] mode);
    logic [127:0]       q;
    logic signed [15:0] l;
    longint             v;
    longint             hi;
    q  = '0;
    hi = (mode == 2'd0) ? 127 : 7;
    for (int i = 0; i < 16; i++) begin
        l = lanes[16*i +: 16];
        v = (longint'(l) * longint'(recip)) >>> 8;
        if (v > hi) begin
            v = hi;
        end else if (v < -hi - 1) begin
            v = -hi - 1;
        end
        if (mode == 2'd0) begin
            q[8*i +: 8] = v[7:0];
        end else begin
            q[4*i +: 4] = v[3:0];
        end
    end
    return q;
endfunction

`default_nettype wire
`endif

// File: bench/ppu_tb.sv
`timescale 1ns/10ps
`include "ppu_ref.svh"
`default_nettype none

module ppu_tb;

    localparam int cycle_limit = 2000;

    typedef struct packed {
        logic [127:0] data;
        logic [3:0]   max_idx;
        logic         near_full;
    } expect_t;

    logic         clk;
    logic         rst_n;
    logic [1:0]   mode;
    logic [383:0] partial_sum;
    logic [7:0]   scale_a;
    logic [7:0]   scale_w;
    logic [7:0]   bias;
    logic         valid;
    logic [127:0] q_data;
    logic         q_valid;

    expect_t exp_q [$];
    int      data_errs = 0;
    int      lat_errs  = 0;
    int      seq_errs  = 0;
    int      cycles    = 0;

    ppu_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .mode        (mode),
        .partial_sum (partial_sum),
        .scale_a     (scale_a),
        .scale_w     (scale_w),
        .bias        (bias),
        .valid       (valid),
        .q_data      (q_data),
        .q_valid     (q_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic expect_t expected_for(input logic [383:0] p, input logic [7:0] sa,
                                             input logic [7:0] sw, input logic [7:0] b,
                                             input logic [1:0] m);
        logic [255:0]       lanes;
        logic signed [15:0] mx;
        expect_t            e;
        int                 idx;
        for (int i = 0; i < 16; i++) begin
            lanes[16*i +: 16] = lane_affine(p[24*i +: 24], sa, sw, b);
        end
        idx         = vector_max_index(lanes);
        mx          = lanes[16*idx +: 16];
        e.data      = quantize_pack(lanes, reciprocal_of(mx, m), m);
        e.max_idx   = 4'(idx);
        // only a small max leaves the top lane within one step of 127
        e.near_full = (m == 2'd0) && (mx > 0) && (mx <= 256);
        return e;
    endfunction

    function automatic logic [7:0] random_scale(input int lo, input int hi, input logic neg);
        return {neg, 4'(lo + $urandom % (hi - lo + 1)), 3'($urandom)};
    endfunction

    function automatic logic [383:0] random_psum();
        logic [383:0] p;
        for (int i = 0; i < 16; i++) begin
            p[24*i +: 24] = 24'($urandom);
        end
        return p;
    endfunction

    task automatic drive_vector(input logic [1:0] m, input logic [383:0] p,
                                input logic [7:0] sa, input logic [7:0] sw, input logic [7:0] b);
        @(posedge clk);
        valid       <= 1'b1;
        mode        <= m;
        partial_sum <= p;
        scale_a     <= sa;
        scale_w     <= sw;
        bias        <= b;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            valid <= 1'b0;
        end
    endtask

    // mostly bursts with an occasional short gap
    task automatic maybe_gap();
        if ($urandom % 3 == 0) begin
            idle_cycles(1 + $urandom % 3);
        end
    endtask

    task automatic report_counts();
        $display("errors: data %0d, latency %0d, sequence %0d", data_errs, lat_errs, seq_errs);
    endtask

    // pop on q_valid, then push the vector the DUT takes at this edge
    always @(posedge clk) begin
        expect_t    head;
        logic [7:0] top_byte;
        if (q_valid) begin
            if (exp_q.size() == 0) begin
                seq_errs++;
                $display("q_valid pulsed with no vector outstanding at %0t", $time);
            end else begin
                head = exp_q.pop_front();
                assert (q_data == head.data) else begin
                    data_errs++;
                    $display("ERR q_data expected %h got %h", head.data, q_data);
                end
                top_byte = q_data[8*head.max_idx +: 8];
                if (head.near_full) begin
                    assert (top_byte == 8'h7e || top_byte == 8'h7f) else begin
                        data_errs++;
                        $display("ERR q_data max lane expected %h got %h", 8'h7f, top_byte);
                    end
                end
            end
        end
        if (rst_n && valid) begin
            exp_q.push_back(expected_for(partial_sum, scale_a, scale_w, bias, mode));
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) valid |-> ##3 q_valid) else begin
        lat_errs++;
        $display("accepted vector gave no q_valid three cycles later, at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n) q_valid |-> $past(valid, 3)) else begin
        lat_errs++;
        $display("q_valid without a vector three cycles earlier, at %0t", $time);
    end

    // non-positive max must give the all-ones reciprocal
    assert property (@(posedge clk) disable iff (!rst_n)
                     (DUT.st1_if.valid && $signed(DUT.st1_if.aux) <= 0)
                     |=> (DUT.st2_if.aux == 16'hffff)) else begin
        data_errs++;
        $display("ERR st2_if.aux expected %h got %h", 16'hffff, $sampled(DUT.st2_if.aux));
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            report_counts();
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int           k;
        int           drain;
        logic         neg;
        logic [383:0] p;
        void'($urandom(32'h8822));
        rst_n       = 1'b0;
        valid       = 1'b0;
        mode        = 2'd0;
        partial_sum = '0;
        scale_a     = 8'd0;
        scale_w     = 8'd0;
        bias        = 8'd0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (q_data == '0) else begin
            data_errs++;
            $display("ERR q_data expected %h got %h after reset", 128'h0, q_data);
        end
        assert (!q_valid) else begin
            lat_errs++;
            $display("ERR q_valid expected %h got %h after reset", 1'b0, q_valid);
        end

        // int8 with random sums and bias
        for (int n = 0; n < 100; n++) begin
            drive_vector(2'd0, random_psum(), random_scale(4, 9, $urandom % 2),
                         random_scale(4, 9, $urandom % 2), 8'($urandom));
            maybe_gap();
        end
        // int4 through every non-int8 mode value
        for (int n = 0; n < 100; n++) begin
            drive_vector(2'(1 + $urandom % 3), random_psum(), random_scale(4, 9, $urandom % 2),
                         random_scale(4, 9, $urandom % 2), 8'($urandom));
            maybe_gap();
        end
        // positive sums through a negative scale so relu zeroes every lane
        for (int n = 0; n < 30; n++) begin
            for (int i = 0; i < 16; i++) begin
                p[24*i +: 24] = {1'b0, 23'($urandom)};
            end
            drive_vector(2'($urandom), p, random_scale(4, 9, 1'b1),
                         random_scale(4, 9, 1'b0), 8'd0);
            maybe_gap();
        end
        // one large lane among negative ones with big scales to force clamping
        for (int n = 0; n < 70; n++) begin
            k   = $urandom % 16;
            neg = $urandom % 2;
            for (int i = 0; i < 16; i++) begin
                p[24*i +: 24] = (i == k) ? {2'b01, 22'($urandom)} : {1'b1, 23'($urandom)};
            end
            drive_vector(2'($urandom), p, random_scale(8, 11, neg), random_scale(8, 11, neg),
                         8'($urandom));
            maybe_gap();
        end
        idle_cycles(1);

        drain = 0;
        while (exp_q.size() != 0 && drain < 20) begin
            @(posedge clk);
            drain++;
        end
        idle_cycles(5);
        if (exp_q.size() != 0) begin
            seq_errs++;
            $display("%0d expected results never appeared on q_data", exp_q.size());
        end

        report_counts();
        if (data_errs + lat_errs + seq_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/ppu_top.sv
`timescale 1ns/10ps
`default_nettype none

module ppu_top (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [1:0]                                            mode,
    input  logic [ppu_cfg_pkg::lane_count*ppu_cfg_pkg::psum_width-1:0] partial_sum,
    input  logic [7:0]                                            scale_a,
    input  logic [7:0]                                            scale_w,
    input  logic [7:0]                                            bias,
    input  logic                                                  valid,
    output logic [ppu_cfg_pkg::lane_count*ppu_cfg_pkg::q_width-1:0]    q_data,
    output logic                                                  q_valid
);

    ppu_cfg_pkg::lane_vec_t affine_lanes;

    // max_stage to reciprocal_stage
    ppu_stage_if st1_if ();
    // reciprocal_stage to quantize_stage
    ppu_stage_if st2_if ();

    // scale, bias, relu, truncate in the input cycle
    vector_affine u_affine (
        .partial_sum (partial_sum),
        .scale_a     (scale_a),
        .scale_w     (scale_w),
        .bias        (bias),
        .lanes       (affine_lanes)
    );

    max_stage u_max (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid    (valid),
        .mode     (mode),
        .lanes_in (affine_lanes),
        .out      (st1_if.src)
    );

    reciprocal_stage u_recip (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (st1_if.dst),
        .out   (st2_if.src)
    );

    quantize_stage u_quant (
        .clk     (clk),
        .rst_n   (rst_n),
        .in      (st2_if.dst),
        .q_data  (q_data),
        .q_valid (q_valid)
    );

endmodule

`default_nettype wire

// File: source/quantize_stage.sv
`timescale 1ns/10ps
`default_nettype none

module quantize_stage (
    input  logic                                                clk,
    input  logic                                                rst_n,
    ppu_stage_if.dst                                            in,
    output logic [ppu_cfg_pkg::lane_count*ppu_cfg_pkg::q_width-1:0] q_data,
    output logic                                                q_valid
);

    // signed lane times unsigned reciprocal needs one extra bit
    logic signed [2*ppu_cfg_pkg::lane_width:0]   prod   [ppu_cfg_pkg::lane_count];
    logic signed [2*ppu_cfg_pkg::lane_width:0]   scaled [ppu_cfg_pkg::lane_count];
    logic signed [ppu_cfg_pkg::q_width-1:0]      sat    [ppu_cfg_pkg::lane_count];
    logic                                        is_int8;
    int                                          hi;
    int                                          lo;
    logic [ppu_cfg_pkg::lane_count*ppu_cfg_pkg::q_width-1:0] packed_q;

    assign is_int8 = (in.mode == ppu_cfg_pkg::QUANT_INT8);
    assign hi      = is_int8 ? ppu_num_pkg::int8_limit : ppu_num_pkg::int4_limit;
    assign lo      = -hi - 1;

    always_comb begin
        packed_q = '0;
        for (int i = 0; i < ppu_cfg_pkg::lane_count; i++) begin
            prod[i]   = in.lanes[i] * $signed({1'b0, in.aux});
            scaled[i] = prod[i] >>> ppu_num_pkg::q88_frac_bits;
            // clamp to the mode's range
            if (scaled[i] > hi) begin
                sat[i] = ppu_cfg_pkg::q_width'(hi);
            end else if (scaled[i] < lo) begin
                sat[i] = ppu_cfg_pkg::q_width'(lo);
            end else begin
                sat[i] = scaled[i][ppu_cfg_pkg::q_width-1:0];
            end
            if (is_int8) begin
                packed_q[i*ppu_cfg_pkg::q_width +: ppu_cfg_pkg::q_width] = sat[i];
            end else begin
                // nibble i of the low half, upper half stays zero
                packed_q[i*(ppu_cfg_pkg::q_width/2) +: ppu_cfg_pkg::q_width/2] =
                    sat[i][ppu_cfg_pkg::q_width/2-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
            q_data  <= '0;
        end else begin
            q_valid <= in.valid;
            // hold the last result between vectors
            if (in.valid) begin
                q_data <= packed_q;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/reciprocal_stage.sv
`timescale 1ns/10ps
`default_nettype none

module reciprocal_stage (
    input  logic     clk,
    input  logic     rst_n,
    ppu_stage_if.dst in,
    ppu_stage_if.src out
);

    logic [ppu_cfg_pkg::lane_width-1:0] limit;
    logic [ppu_cfg_pkg::lane_width-1:0] numer;
    logic [ppu_cfg_pkg::lane_width-1:0] recip;

    always_comb begin
        limit = (in.mode == ppu_cfg_pkg::QUANT_INT8)
              ? ppu_cfg_pkg::lane_width'(ppu_num_pkg::int8_limit)
              : ppu_cfg_pkg::lane_width'(ppu_num_pkg::int4_limit);
        // limit in q8.8
        numer = limit << ppu_num_pkg::q88_frac_bits;
        if (in.aux <= 0) begin
            // nothing positive to scale against
            recip = ppu_num_pkg::recip_all_ones;
        end else begin
            recip = numer / $unsigned(in.aux);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            out.lanes <= in.lanes;
            out.mode  <= in.mode;
            out.aux   <= recip;
        end
    end

endmodule

`default_nettype wire

// File: source/max_stage.sv
`timescale 1ns/10ps
`default_nettype none

module max_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid,
    input  logic [1:0]             mode,
    input  ppu_cfg_pkg::lane_vec_t lanes_in,
    ppu_stage_if.src               out
);

    // level 0 holds the lanes, each level halves the candidates
    ppu_cfg_pkg::lane_t tree [ppu_cfg_pkg::tree_levels+1][ppu_cfg_pkg::lane_count];
    ppu_cfg_pkg::lane_t vec_max;

    always_comb begin
        tree    = '{default: '0};
        tree[0] = lanes_in;
        for (int l = 1; l <= ppu_cfg_pkg::tree_levels; l++) begin
            for (int i = 0; i < (ppu_cfg_pkg::lane_count >> l); i++) begin
                tree[l][i] = (tree[l-1][2*i] > tree[l-1][2*i+1]) ? tree[l-1][2*i]
                                                                 : tree[l-1][2*i+1];
            end
        end
    end

    assign vec_max = tree[ppu_cfg_pkg::tree_levels][0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= valid;
        end
    end

    // payload only moves on a valid strobe
    always_ff @(posedge clk) begin
        if (valid) begin
            out.lanes <= lanes_in;
            out.mode  <= ppu_cfg_pkg::quant_mode_e'(mode);
            out.aux   <= vec_max;
        end
    end

endmodule

`default_nettype wire

// File: source/vector_affine.sv
`timescale 1ns/10ps
`default_nettype none

module vector_affine (
    input  logic [ppu_cfg_pkg::lane_count*ppu_cfg_pkg::psum_width-1:0] partial_sum,
    input  logic [7:0]                                                 scale_a,
    input  logic [7:0]                                                 scale_w,
    input  logic [7:0]                                                 bias,
    output ppu_cfg_pkg::lane_vec_t                                     lanes
);

    // e4m3 to signed q8.8, large exponents wrap at 16 bits
    function automatic logic signed [15:0] fp8_to_q88(input logic [7:0] fp);
        logic [3:0]  exp_f;
        logic [15:0] base;
        logic [15:0] mag;
        exp_f = fp[6:ppu_num_pkg::fp8_mant_bits];
        base  = ppu_num_pkg::q88_one
              + (16'(fp[ppu_num_pkg::fp8_mant_bits-1:0])
                 << (ppu_num_pkg::q88_frac_bits - ppu_num_pkg::fp8_mant_bits));
        if (exp_f >= ppu_num_pkg::fp8_exp_bias) begin
            mag = base << (exp_f - ppu_num_pkg::fp8_exp_bias);
        end else begin
            mag = base >> (ppu_num_pkg::fp8_exp_bias - exp_f);
        end
        return fp[7] ? -mag : mag;
    endfunction

    logic signed [15:0]                         scale_a_q;
    logic signed [15:0]                         scale_w_q;
    logic signed [ppu_num_pkg::scaled_width-1:0] scale_a_ext;
    logic signed [ppu_num_pkg::scaled_width-1:0] scale_w_ext;
    logic signed [ppu_num_pkg::scaled_width-1:0] bias_ext;

    assign scale_a_q   = fp8_to_q88(scale_a);
    assign scale_w_q   = fp8_to_q88(scale_w);
    // widen once so every lane product runs in 40 bits
    assign scale_a_ext = scale_a_q;
    assign scale_w_ext = scale_w_q;
    // bias is unsigned and lands at bits 23:16
    assign bias_ext    = $signed(ppu_num_pkg::scaled_width'(bias) << ppu_num_pkg::bias_shift);

    for (genvar i = 0; i < ppu_cfg_pkg::lane_count; i++) begin : g_lane
        logic signed [ppu_cfg_pkg::psum_width-1:0]   psum;
        logic signed [ppu_num_pkg::scaled_width-1:0] psum_ext;
        logic signed [ppu_num_pkg::scaled_width-1:0] after_a;
        logic signed [ppu_num_pkg::scaled_width-1:0] after_w;
        logic signed [ppu_num_pkg::scaled_width-1:0] biased;

        assign psum     = partial_sum[i*ppu_cfg_pkg::psum_width +: ppu_cfg_pkg::psum_width];
        assign psum_ext = psum;

        // two q8.8 multiplies, each dropping the fraction bits
        assign after_a  = (psum_ext * scale_a_ext) >>> ppu_num_pkg::q88_frac_bits;
        assign after_w  = (after_a * scale_w_ext) >>> ppu_num_pkg::q88_frac_bits;
        assign biased   = after_w + bias_ext;

        // relu, then keep bits 31:16
        assign lanes[i] = (biased < 0) ? '0
                        : biased[ppu_num_pkg::trunc_lsb +: ppu_cfg_pkg::lane_width];
    end

endmodule

`default_nettype wire

// File: source/ppu_stage_if.sv
`timescale 1ns/10ps
`default_nettype none

interface ppu_stage_if;

    logic                    valid;
    ppu_cfg_pkg::quant_mode_e mode;
    ppu_cfg_pkg::lane_vec_t   lanes;
    // vector max after stage 1, reciprocal after stage 2
    ppu_cfg_pkg::lane_t       aux;

    modport src (
        output valid,
        output mode,
        output lanes,
        output aux
    );

    modport dst (
        input valid,
        input mode,
        input lanes,
        input aux
    );

endinterface

`default_nettype wire

// File: source/ppu_num_pkg.sv
`default_nettype none

package ppu_num_pkg;

    // fp8 e4m3 scale format
    localparam int fp8_exp_bias  = 7;
    localparam int fp8_mant_bits = 3;

    // q8.8 fixed point
    localparam logic [15:0] q88_one = 16'd256;
    localparam int q88_frac_bits    = 8;

    // affine datapath
    localparam int scaled_width = 40;
    localparam int bias_shift   = 16;
    // lowest bit kept when cutting a scaled lane to 16 bits
    localparam int trunc_lsb    = 16;

    // quantization range, positive side
    localparam int int8_limit = 127;
    localparam int int4_limit = 7;

    // reciprocal used when the vector max is not positive
    localparam logic [15:0] recip_all_ones = 16'hffff;

endpackage

`default_nettype wire

// File: source/ppu_cfg_pkg.sv
`default_nettype none

package ppu_cfg_pkg;

    // vector geometry
    localparam int lane_count = 16;
    localparam int psum_width = 24;
    localparam int lane_width = 16;

    // one output slot per lane, int8 uses it all, int4 uses half
    localparam int q_width = 8;

    // levels in the max comparison tree
    localparam int tree_levels = $clog2(lane_count);

    // one lane after truncation
    typedef logic signed [lane_width-1:0] lane_t;

    // whole vector, lane 0 first
    typedef lane_t lane_vec_t [lane_count];

    // quantization target, anything but int8 runs as int4
    typedef enum logic [1:0] {
        QUANT_INT8 = 2'd0,
        QUANT_INT4 = 2'd1
    } quant_mode_e;

endpackage

`default_nettype wire
